//--- autotest.f
rtl/autotest_pkg.sv
rtl/autotest_ctrl.sv
rtl/field_capture.sv
rtl/uut_monitor.sv
rtl/result_serializer.sv
rtl/autotest_top.sv
verification/sd_uut_model.sv
verification/tb_autotest.sv

//--- rtl/autotest_ctrl.sv
// autotest_ctrl: test sequencing FSM, SD request levels, byte counter, block address counter
module autotest_ctrl #(
    parameter autotest_pkg::blk_addr_t START_BLOCK = 32'h0010_0000
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      spi_busy_i,
    input  autotest_pkg::sig_t        sig_i,
    input  logic                      run_done_i,
    output logic                      spi_rst_o,
    output logic                      spi_r_block_o,
    output logic                      spi_r_byte_o,
    output logic                      spi_w_block_o,
    output logic                      spi_w_byte_o,
    output autotest_pkg::blk_addr_t   spi_block_addr_o,
    output logic                      uut_rst_o,
    output logic                      clear_o,
    output logic                      run_o,
    output logic                      rd_byte_valid_o,
    output autotest_pkg::byte_idx_t   rd_byte_idx_o,
    output logic                      wr_load_o,
    output autotest_pkg::byte_idx_t   wr_byte_idx_o
);
    import autotest_pkg::*;

    ctrl_state_t state_q;
    logic        ack_q;
    logic        setup_q;
    byte_idx_t   byte_cnt_q;
    byte_idx_t   byte_nxt;
    blk_addr_t   addr_q;
    logic        req_on;
    logic        step_done;
    logic        last_byte;

    assign byte_nxt  = byte_cnt_q + 1'b1;
    assign last_byte = (byte_cnt_q == LAST_BYTE);

    // ack_q marks that busy was seen high for the pending request
    assign step_done = ack_q && !spi_busy_i;

    // states that hold a request towards the SD host
    always_comb
    begin
        case (state_q)
            ST_SD_RST, ST_RD_BLOCK, ST_RD_BYTE, ST_WR_BLOCK:
                req_on = 1'b1;
            ST_WR_BYTE:
                req_on = !setup_q;
            default:
                req_on = 1'b0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q    <= ST_IDLE;
            ack_q      <= 1'b0;
            setup_q    <= 1'b0;
            byte_cnt_q <= '0;
            addr_q     <= START_BLOCK;
        end
        else
        begin
            if (req_on && !ack_q && spi_busy_i)
                ack_q <= 1'b1;
            else if (step_done)
                ack_q <= 1'b0;

            case (state_q)
                ST_IDLE:
                begin
                    byte_cnt_q <= '0;
                    state_q    <= ST_SD_RST;
                end
                ST_SD_RST:
                begin
                    if (step_done)
                        state_q <= ST_RD_BLOCK;
                end
                ST_RD_BLOCK:
                begin
                    if (step_done)
                        state_q <= ST_RD_BYTE;
                end
                ST_RD_BYTE:
                begin
                    if (step_done)
                    begin
                        if (last_byte)
                            state_q <= ST_SIG_CHECK;
                        else
                            byte_cnt_q <= byte_nxt;
                    end
                end
                ST_SIG_CHECK:
                begin
                    byte_cnt_q <= '0;
                    if (sig_i == SIGNATURE_VALUE)
                        state_q <= ST_RUN;
                    else
                        state_q <= ST_HALT;
                end
                ST_RUN:
                begin
                    if (run_done_i)
                        state_q <= ST_WR_BLOCK;
                end
                ST_WR_BLOCK:
                begin
                    if (step_done)
                    begin
                        setup_q <= 1'b1;
                        state_q <= ST_WR_BYTE;
                    end
                end
                ST_WR_BYTE:
                begin
                    // one idle cycle lets the loaded byte settle before the request
                    if (setup_q)
                        setup_q <= 1'b0;
                    else if (step_done)
                    begin
                        if (last_byte)
                            state_q <= ST_ADVANCE;
                        else
                        begin
                            byte_cnt_q <= byte_nxt;
                            setup_q    <= 1'b1;
                        end
                    end
                end
                ST_ADVANCE:
                begin
                    addr_q  <= addr_q + 1'b1;
                    state_q <= ST_IDLE;
                end
                default:
                    state_q <= ST_HALT;
            endcase
        end
    end

    assign spi_rst_o        = (state_q == ST_SD_RST) && !ack_q;
    assign spi_r_block_o    = (state_q == ST_RD_BLOCK) || (state_q == ST_RD_BYTE);
    assign spi_r_byte_o     = (state_q == ST_RD_BYTE) && !ack_q;
    assign spi_w_block_o    = (state_q == ST_WR_BLOCK) || (state_q == ST_WR_BYTE);
    assign spi_w_byte_o     = (state_q == ST_WR_BYTE) && !setup_q && !ack_q;
    assign spi_block_addr_o = addr_q;

    assign run_o     = (state_q == ST_RUN);
    assign uut_rst_o = !run_o;
    assign clear_o   = (state_q == ST_IDLE);

    // read byte is on spi_data_out_i once busy falls
    assign rd_byte_valid_o = (state_q == ST_RD_BYTE) && step_done;
    assign rd_byte_idx_o   = byte_cnt_q;

    // load the next outgoing byte as the previous step completes
    assign wr_load_o = step_done &&
                       ((state_q == ST_WR_BLOCK) ||
                        ((state_q == ST_WR_BYTE) && !setup_q && !last_byte));
    assign wr_byte_idx_o = (state_q == ST_WR_BYTE) ? byte_nxt : byte_cnt_q;

    a_byte_req_excl: assert property (@(posedge clk) disable iff (rst)
        !(spi_r_byte_o && spi_w_byte_o))
        else $error("read and write byte requests overlap");

    a_rd_byte_in_block: assert property (@(posedge clk) disable iff (rst)
        spi_r_byte_o |-> spi_r_block_o)
        else $error("read byte request outside block read");

    a_wr_byte_in_block: assert property (@(posedge clk) disable iff (rst)
        spi_w_byte_o |-> spi_w_block_o)
        else $error("write byte request outside block write");

endmodule

//--- rtl/autotest_pkg.sv
// autotest_pkg: payload types, block field offsets and sizes, controller state type
package autotest_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] sig_t;
    typedef logic [79:0] iv_t;
    typedef logic [79:0] key_t;
    typedef logic [63:0] block_t;
    typedef logic [63:0] cycles_t;
    typedef logic [9:0]  byte_idx_t;
    typedef logic [31:0] blk_addr_t;

    localparam sig_t SIGNATURE_VALUE = 32'hAABB_CCDD;
    localparam int   BLOCK_BYTES     = 512;
    localparam byte_idx_t LAST_BYTE  = byte_idx_t'(BLOCK_BYTES - 1);

    // byte offsets inside the SD block, signature is MSB first, the rest LSB first
    localparam int SIG_OFFSET    = 0;
    localparam int IV_OFFSET     = 4;
    localparam int KEY_OFFSET    = 14;
    localparam int RESULT_OFFSET = 24;
    localparam int CYCLES_OFFSET = 32;

    localparam int SIG_BYTES    = $bits(sig_t) / 8;
    localparam int IV_BYTES     = $bits(iv_t) / 8;
    localparam int KEY_BYTES    = $bits(key_t) / 8;
    localparam int RESULT_BYTES = $bits(block_t) / 8;
    localparam int CYCLES_BYTES = $bits(cycles_t) / 8;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_SD_RST,
        ST_RD_BLOCK,
        ST_RD_BYTE,
        ST_SIG_CHECK,
        ST_RUN,
        ST_WR_BLOCK,
        ST_WR_BYTE,
        ST_ADVANCE,
        ST_HALT
    } ctrl_state_t;

endpackage

//--- rtl/autotest_top.sv
// autotest_top: controller, header captures, run monitor and result serializer
module autotest_top #(
    parameter autotest_pkg::blk_addr_t START_BLOCK    = 32'h0010_0000,
    parameter autotest_pkg::cycles_t   TIMEOUT_CYCLES = 64'd1 << 40
) (
    input  logic                    clk,
    input  logic                    rst,
    // SD host
    input  logic                    spi_busy_i,
    input  autotest_pkg::byte_t     spi_data_out_i,
    output logic                    spi_rst_o,
    output logic                    spi_r_block_o,
    output logic                    spi_r_byte_o,
    output logic                    spi_w_block_o,
    output logic                    spi_w_byte_o,
    output autotest_pkg::blk_addr_t spi_block_addr_o,
    output autotest_pkg::byte_t     spi_data_in_o,
    // cipher core
    output logic                    uut_rst_o,
    output autotest_pkg::iv_t       uut_iv_o,
    output autotest_pkg::key_t      uut_key_o,
    input  autotest_pkg::block_t    uut_block_i,
    input  logic                    uut_end_i
);
    import autotest_pkg::*;

    logic      clear;
    logic      run;
    logic      run_done;
    logic      rd_byte_valid;
    byte_idx_t rd_byte_idx;
    logic      wr_load;
    byte_idx_t wr_byte_idx;
    sig_t      sig;
    cycles_t   cycles;
    block_t    result;

    autotest_ctrl #(
        .START_BLOCK (START_BLOCK)
    ) u_ctrl (
        .clk              (clk),
        .rst              (rst),
        .spi_busy_i       (spi_busy_i),
        .sig_i            (sig),
        .run_done_i       (run_done),
        .spi_rst_o        (spi_rst_o),
        .spi_r_block_o    (spi_r_block_o),
        .spi_r_byte_o     (spi_r_byte_o),
        .spi_w_block_o    (spi_w_block_o),
        .spi_w_byte_o     (spi_w_byte_o),
        .spi_block_addr_o (spi_block_addr_o),
        .uut_rst_o        (uut_rst_o),
        .clear_o          (clear),
        .run_o            (run),
        .rd_byte_valid_o  (rd_byte_valid),
        .rd_byte_idx_o    (rd_byte_idx),
        .wr_load_o        (wr_load),
        .wr_byte_idx_o    (wr_byte_idx)
    );

    field_capture #(.payload_t(sig_t), .OFFSET(SIG_OFFSET), .MSB_FIRST(1'b1)) u_sig_capture (
        .clk (clk), .rst (rst), .clear_i (clear),
        .rd_byte_valid_i (rd_byte_valid), .rd_byte_idx_i (rd_byte_idx),
        .data_i (spi_data_out_i), .field_o (sig)
    );

    field_capture #(.payload_t(iv_t), .OFFSET(IV_OFFSET), .MSB_FIRST(1'b0)) u_iv_capture (
        .clk (clk), .rst (rst), .clear_i (clear),
        .rd_byte_valid_i (rd_byte_valid), .rd_byte_idx_i (rd_byte_idx),
        .data_i (spi_data_out_i), .field_o (uut_iv_o)
    );

    field_capture #(.payload_t(key_t), .OFFSET(KEY_OFFSET), .MSB_FIRST(1'b0)) u_key_capture (
        .clk (clk), .rst (rst), .clear_i (clear),
        .rd_byte_valid_i (rd_byte_valid), .rd_byte_idx_i (rd_byte_idx),
        .data_i (spi_data_out_i), .field_o (uut_key_o)
    );

    uut_monitor #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) u_monitor (
        .clk         (clk),
        .rst         (rst),
        .clear_i     (clear),
        .run_i       (run),
        .uut_end_i   (uut_end_i),
        .uut_block_i (uut_block_i),
        .run_done_o  (run_done),
        .cycles_o    (cycles),
        .result_o    (result)
    );

    result_serializer u_serializer (
        .clk           (clk),
        .rst           (rst),
        .wr_load_i     (wr_load),
        .wr_byte_idx_i (wr_byte_idx),
        .sig_i         (sig),
        .iv_i          (uut_iv_o),
        .key_i         (uut_key_o),
        .result_i      (result),
        .cycles_i      (cycles),
        .spi_data_in_o (spi_data_in_o)
    );

endmodule

//--- rtl/field_capture.sv
// field_capture: byte-wise capture of one header field from the SD read stream
module field_capture #(
    parameter type payload_t = autotest_pkg::sig_t,
    parameter int  OFFSET    = 0,
    parameter bit  MSB_FIRST = 1'b0
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    clear_i,
    input  logic                    rd_byte_valid_i,
    input  autotest_pkg::byte_idx_t rd_byte_idx_i,
    input  autotest_pkg::byte_t     data_i,
    output payload_t                field_o
);
    import autotest_pkg::*;

    localparam int NBYTES = $bits(payload_t) / 8;

    payload_t  field_q;
    byte_idx_t rel;
    byte_idx_t lane;
    logic      in_span;

    assign rel     = rd_byte_idx_i - byte_idx_t'(OFFSET);
    assign in_span = (rd_byte_idx_i >= byte_idx_t'(OFFSET)) && (rel < byte_idx_t'(NBYTES));

    // signature lands top lane first
    assign lane = MSB_FIRST ? (byte_idx_t'(NBYTES - 1) - rel) : rel;

    always_ff @(posedge clk)
    begin
        if (rst || clear_i)
            field_q <= '0;
        else if (rd_byte_valid_i && in_span)
            field_q[8 * lane +: 8] <= data_i;
    end

    assign field_o = field_q;

    a_whole_bytes: assert property (@(posedge clk) ($bits(payload_t) % 8) == 0)
        else $error("payload width is not a whole number of bytes");

endmodule

//--- rtl/result_serializer.sv
// result_serializer: maps byte positions of the result block to fields, registers each byte
module result_serializer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wr_load_i,
    input  autotest_pkg::byte_idx_t wr_byte_idx_i,
    input  autotest_pkg::sig_t      sig_i,
    input  autotest_pkg::iv_t       iv_i,
    input  autotest_pkg::key_t      key_i,
    input  autotest_pkg::block_t    result_i,
    input  autotest_pkg::cycles_t   cycles_i,
    output autotest_pkg::byte_t     spi_data_in_o
);
    import autotest_pkg::*;

    function automatic logic in_field(int pos, int offset, int nbytes);
        return (pos >= offset) && (pos < offset + nbytes);
    endfunction

    int    pos;
    byte_t sel_byte;
    byte_t data_q;

    assign pos = int'(wr_byte_idx_i);

    // unused positions are sent as zero
    always_comb
    begin
        sel_byte = '0;
        if (in_field(pos, SIG_OFFSET, SIG_BYTES))
            sel_byte = byte_t'(sig_i >> (8 * (SIG_BYTES - 1 - (pos - SIG_OFFSET))));
        else if (in_field(pos, IV_OFFSET, IV_BYTES))
            sel_byte = byte_t'(iv_i >> (8 * (pos - IV_OFFSET)));
        else if (in_field(pos, KEY_OFFSET, KEY_BYTES))
            sel_byte = byte_t'(key_i >> (8 * (pos - KEY_OFFSET)));
        else if (in_field(pos, RESULT_OFFSET, RESULT_BYTES))
            sel_byte = byte_t'(result_i >> (8 * (pos - RESULT_OFFSET)));
        else if (in_field(pos, CYCLES_OFFSET, CYCLES_BYTES))
            sel_byte = byte_t'(cycles_i >> (8 * (pos - CYCLES_OFFSET)));
    end

    // held until the next load, so stable through the whole byte write
    always_ff @(posedge clk)
    begin
        if (rst)
            data_q <= '0;
        else if (wr_load_i)
            data_q <= sel_byte;
    end

    assign spi_data_in_o = data_q;

endmodule

//--- rtl/uut_monitor.sv
// uut_monitor: run cycle counter, timeout detection, capture of the core output block
module uut_monitor #(
    parameter autotest_pkg::cycles_t TIMEOUT_CYCLES = 64'd1 << 40
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clear_i,
    input  logic                  run_i,
    input  logic                  uut_end_i,
    input  autotest_pkg::block_t  uut_block_i,
    output logic                  run_done_o,
    output autotest_pkg::cycles_t cycles_o,
    output autotest_pkg::block_t  result_o
);
    import autotest_pkg::*;

    cycles_t cnt_q;
    block_t  result_q;
    logic    limit_hit;

    assign limit_hit  = (cnt_q == TIMEOUT_CYCLES);
    assign run_done_o = run_i && (uut_end_i || limit_hit);

    // counts edges with the core running and not yet done
    always_ff @(posedge clk)
    begin
        if (rst || clear_i)
            cnt_q <= '0;
        else if (run_i && !run_done_o)
            cnt_q <= cnt_q + 1'b1;
    end

    // output block sampled in the cycle the run ends
    always_ff @(posedge clk)
    begin
        if (clear_i)
            result_q <= '0;
        else if (run_done_o)
            result_q <= uut_block_i;
    end

    assign cycles_o = cnt_q;
    assign result_o = result_q;

    a_cnt_capped: assert property (@(posedge clk) disable iff (rst)
        cnt_q <= TIMEOUT_CYCLES)
        else $error("run counter above timeout limit");

    // controller must leave the run on the edge after run_done
    a_run_drops: assert property (@(posedge clk) disable iff (rst)
        run_done_o |=> !run_i)
        else $error("run still high after run_done");

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the autotest simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f autotest.f --top-module tb_autotest -o sim_autotest
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_autotest > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
exit 0

//--- verification/sd_uut_model.sv
// sd_uut_model: SD host with random busy latency and block images, cipher core with end delay
module sd_uut_model (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    spi_rst_i,
    input  logic                    spi_r_block_i,
    input  logic                    spi_r_byte_i,
    input  logic                    spi_w_block_i,
    input  logic                    spi_w_byte_i,
    input  autotest_pkg::blk_addr_t spi_block_addr_i,
    input  autotest_pkg::byte_t     spi_data_in_i,
    output logic                    spi_busy_o,
    output autotest_pkg::byte_t     spi_data_out_o,
    input  logic                    uut_rst_i,
    input  autotest_pkg::iv_t       uut_iv_i,
    input  autotest_pkg::key_t      uut_key_i,
    output autotest_pkg::block_t    uut_block_o,
    output logic                    uut_end_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import autotest_pkg::*;

    localparam int MAX_GAP  = 3;
    localparam int MAX_BUSY = 4;

    // images keyed by {block address, byte index}
    byte_t rd_img [logic [41:0]];
    byte_t wr_img [logic [41:0]];
    int    wr_bytes [blk_addr_t];
    int    end_delay [blk_addr_t];
    int    blocks_read;
    int    blocks_written;
    int    requests;
    int    byte_idx;
    int    run_cnt;
    logic [4:0] req_now;
    logic [4:0] req_prev;
    logic [4:0] req_rise;

    // stand-in for the cipher, also used by the checker
    function automatic block_t core_block(key_t key, iv_t iv);
        return {key[79:48] ^ iv[31:0], key[31:0] + iv[79:48]} ^ {iv[63:32], key[63:32]};
    endfunction

    task automatic serve(input int kind);
        logic [41:0] k;
        repeat ($urandom_range(MAX_GAP)) @(posedge clk);
        spi_busy_o <= 1'b1;
        repeat (1 + $urandom_range(MAX_BUSY - 1)) @(posedge clk);
        k = {spi_block_addr_i, 10'(byte_idx)};
        if (kind == 2)
        begin
            spi_data_out_o <= rd_img[k];
            byte_idx++;
            if (byte_idx == BLOCK_BYTES)
                blocks_read++;
        end
        else if (kind == 0)
        begin
            wr_img[k] = spi_data_in_i;
            wr_bytes[spi_block_addr_i] = wr_bytes[spi_block_addr_i] + 1;
            byte_idx++;
            if (byte_idx == BLOCK_BYTES)
                blocks_written++;
        end
        spi_busy_o <= 1'b0;
    endtask

    // SD host, one request served at a time
    initial
    begin
        spi_busy_o     = 1'b0;
        spi_data_out_o = '0;
        req_prev       = '0;
        blocks_read    = 0;
        blocks_written = 0;
        requests       = 0;
        byte_idx       = 0;
        forever
        begin
            @(posedge clk);
            req_now  = {spi_rst_i, spi_r_block_i, spi_r_byte_i, spi_w_block_i, spi_w_byte_i};
            req_rise = req_now & ~req_prev;
            req_prev = req_now;
            if (!rst && req_rise != '0)
            begin
                requests++;
                if (req_rise[3] || req_rise[1])
                    byte_idx = 0;
                if (req_rise[4])
                    serve(4);
                else if (req_rise[3])
                    serve(3);
                else if (req_rise[2])
                    serve(2);
                else if (req_rise[1])
                    serve(1);
                else
                    serve(0);
            end
        end
    end

    // cipher core, ends end_delay cycles after its reset drops
    initial
    begin
        uut_end_o   = 1'b0;
        uut_block_o = '0;
        run_cnt     = 0;
        forever
        begin
            @(posedge clk);
            uut_block_o <= core_block(uut_key_i, uut_iv_i);
            if (uut_rst_i)
            begin
                run_cnt = 0;
                uut_end_o <= 1'b0;
            end
            else
            begin
                run_cnt++;
                if (run_cnt >= end_delay[spi_block_addr_i])
                    uut_end_o <= 1'b1;
            end
        end
    end

endmodule

//--- verification/tb_autotest.sv
// tb_autotest: random SD blocks, checks of each written result block, run counting, watchdog
module tb_autotest;
    timeunit 1ns;
    timeprecision 1ps;
    import autotest_pkg::*;

    localparam blk_addr_t START_BLOCK = 32'd16;
    localparam int LIMIT           = 300;
    localparam int NUM_TESTS       = 5;
    localparam int BAD_TEST        = NUM_TESTS - 1;
    localparam int MAX_STEP_CYCLES = 12;
    localparam int HALT_WATCH      = 2000;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (1100 * MAX_STEP_CYCLES + 400) + HALT_WATCH;

    logic      clk;
    logic      rst;
    logic      spi_busy;
    byte_t     spi_data_out;
    logic      spi_rst;
    logic      spi_r_block;
    logic      spi_r_byte;
    logic      spi_w_block;
    logic      spi_w_byte;
    blk_addr_t spi_block_addr;
    byte_t     spi_data_in;
    logic      uut_rst;
    iv_t       uut_iv;
    key_t      uut_key;
    block_t    uut_block;
    logic      uut_end;
    int        errors;
    int        other_errors;
    int        req_mark;
    int        delays [NUM_TESTS];
    int        run_edges [blk_addr_t];

    autotest_top #(
        .START_BLOCK    (START_BLOCK),
        .TIMEOUT_CYCLES (cycles_t'(LIMIT))
    ) autotest_top_inst (
        .clk (clk), .rst (rst),
        .spi_busy_i (spi_busy), .spi_data_out_i (spi_data_out),
        .spi_rst_o (spi_rst), .spi_r_block_o (spi_r_block), .spi_r_byte_o (spi_r_byte),
        .spi_w_block_o (spi_w_block), .spi_w_byte_o (spi_w_byte),
        .spi_block_addr_o (spi_block_addr), .spi_data_in_o (spi_data_in),
        .uut_rst_o (uut_rst), .uut_iv_o (uut_iv), .uut_key_o (uut_key),
        .uut_block_i (uut_block), .uut_end_i (uut_end)
    );

    sd_uut_model model_inst (
        .clk (clk), .rst (rst),
        .spi_rst_i (spi_rst), .spi_r_block_i (spi_r_block), .spi_r_byte_i (spi_r_byte),
        .spi_w_block_i (spi_w_block), .spi_w_byte_i (spi_w_byte),
        .spi_block_addr_i (spi_block_addr), .spi_data_in_i (spi_data_in),
        .spi_busy_o (spi_busy), .spi_data_out_o (spi_data_out),
        .uut_rst_i (uut_rst), .uut_iv_i (uut_iv), .uut_key_i (uut_key),
        .uut_block_o (uut_block), .uut_end_o (uut_end)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // edges with the core out of reset and not finished, per block address
    always @(negedge clk)
    begin
        if (!rst && !uut_rst && !uut_end)
            run_edges[spi_block_addr] = run_edges[spi_block_addr] + 1;
    end

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("FAIL t=%0t %s got=%0h expected=%0h", $time, name, got, exp);
        end
    endtask

    function automatic byte_t image_byte(blk_addr_t addr, int i);
        return model_inst.rd_img[{addr, 10'(i)}];
    endfunction

    function automatic byte_t written_byte(blk_addr_t addr, int i);
        return model_inst.wr_img[{addr, 10'(i)}];
    endfunction

    task automatic build_block(input blk_addr_t addr, input bit good, input int delay);
        sig_t sig;
        sig = good ? SIGNATURE_VALUE : ~SIGNATURE_VALUE;
        for (int i = 0; i < BLOCK_BYTES; i++)
            model_inst.rd_img[{addr, 10'(i)}] = 8'($urandom);
        // signature goes most significant byte first
        for (int i = 0; i < 4; i++)
            model_inst.rd_img[{addr, 10'(i)}] = sig[8 * (3 - i) +: 8];
        model_inst.end_delay[addr] = delay;
        model_inst.wr_bytes[addr]  = 0;
        run_edges[addr] = 0;
    endtask

    task automatic check_block(input blk_addr_t addr, input int delay);
        iv_t     iv;
        key_t    key;
        block_t  res;
        cycles_t cnt;
        cycles_t got_cnt;
        byte_t   exp;
        for (int i = 0; i < 10; i++)
        begin
            iv[8 * i +: 8]  = image_byte(addr, 4 + i);
            key[8 * i +: 8] = image_byte(addr, 14 + i);
        end
        res = model_inst.core_block(key, iv);
        cnt = cycles_t'((run_edges[addr] > LIMIT) ? LIMIT : run_edges[addr]);
        check_value($sformatf("bytes written to block %0d", addr),
                    64'(model_inst.wr_bytes[addr]), 64'(BLOCK_BYTES));
        for (int i = 0; i < BLOCK_BYTES; i++)
        begin
            if (i < 24)
                exp = image_byte(addr, i);
            else if (i < 32)
                exp = res[8 * (i - 24) +: 8];
            else if (i < 40)
                exp = cnt[8 * (i - 32) +: 8];
            else
                exp = '0;
            check_value($sformatf("spi_data_in_o block %0d byte %0d", addr, i),
                        64'(written_byte(addr, i)), 64'(exp));
        end
        for (int i = 0; i < 8; i++)
            got_cnt[8 * i +: 8] = written_byte(addr, 32 + i);
        if (delay > LIMIT)
            check_value("cycles field at timeout", got_cnt, 64'(LIMIT));
    endtask

    initial
    begin
        void'($urandom(70));
        rst          = 1'b1;
        errors       = 0;
        other_errors = 0;
        for (int t = 0; t < NUM_TESTS; t++)
        begin
            // test 1 always runs past the limit
            delays[t] = (t == 1) ? 301 + $urandom_range(99) : 1 + $urandom_range(399);
            build_block(START_BLOCK + blk_addr_t'(t), t != BAD_TEST, delays[t]);
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int t = 0; t < BAD_TEST; t++)
        begin
            while (model_inst.blocks_written < t + 1)
                @(negedge clk);
            check_value("spi_block_addr_o", 64'(spi_block_addr), 64'(START_BLOCK + blk_addr_t'(t)));
            check_block(START_BLOCK + blk_addr_t'(t), delays[t]);
        end
        while (model_inst.blocks_read < NUM_TESTS)
            @(negedge clk);
        check_value("spi_block_addr_o", 64'(spi_block_addr),
                    64'(START_BLOCK + blk_addr_t'(BAD_TEST)));
        req_mark = model_inst.requests;
        repeat (HALT_WATCH) @(negedge clk);
        if (model_inst.requests != req_mark)
        begin
            other_errors++;
            $display("ERROR: SD request issued after the block with a bad signature");
        end
        check_value("bytes written to bad block",
                    64'(model_inst.wr_bytes[START_BLOCK + blk_addr_t'(BAD_TEST)]), 64'd0);
        $display("errors: %0d value mismatches, %0d other failures", errors, other_errors);
        if (errors == 0 && other_errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles, the DUT stalled", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule
